/* dma_fe_cases.txt */
# request: test op arga argb rsp exp nburst (rsp 1 expects a reply carrying exp)
# burst:   burst src dst len src_obi dst_obi, nburst of them right after their copy
copy_1d 00 80000000 1 0 0 0
copy_1d 01 10000100 0 0 0 0
copy_1d 03 40 0 1 1 1
burst 180000000 10000100 40 0 1
copy_2d 06 100 200 0 0 0
copy_2d 07 3 0 0 0 0
copy_2d 00 10000000 0 0 0 0
copy_2d 01 20000000 0 0 0 0
copy_2d 00200002 10 0 1 2 3
burst 10000000 20000000 10 1 0
burst 10000100 20000200 10 1 0
burst 10000200 20000400 10 1 0
copy_2d 03 8 0 1 3 1
burst 10000000 20000000 8 1 0
obi_edge 00 1001ffc0 0 0 0 0
obi_edge 01 10020000 0 0 0 0
obi_edge 03 20 2 1 4 3
burst 1001ffc0 10020000 20 1 0
burst 100200c0 10020200 20 0 0
burst 100201c0 10020400 20 0 0
status 00100004 0 0 1 5 0
status 05 0 0 1 4 0
status 05 0 2 1 0 0
status 04 0 0 1 4 0

/* dma_fe_params.svh */
//--------------------------------------------------------------------
// DMA frontend parameters
// widths, accelerator function codes and the local memory region
//--------------------------------------------------------------------
`ifndef DMA_FE_PARAMS_SVH
`define DMA_FE_PARAMS_SVH

`define DMA_ADDR_WIDTH   48
`define DMA_DATA_WIDTH   64
`define DMA_ID_WIDTH     32
`define DMA_ACC_ID_WIDTH 5
`define DMA_REP_WIDTH    32
`define DMA_FIFO_DEPTH   3

// function codes in the low seven bits of the instruction word
`define DMA_OP_DMSRC   7'h00
`define DMA_OP_DMDST   7'h01
`define DMA_OP_DMCPYI  7'h02
`define DMA_OP_DMCPY   7'h03
`define DMA_OP_DMSTATI 7'h04
`define DMA_OP_DMSTAT  7'h05
`define DMA_OP_DMSTR   7'h06
`define DMA_OP_DMREP   7'h07

// two-bit immediate config / status selector
`define DMA_IMM_LSB 20

// TCDM window, everything else goes to the system bus
`define DMA_TCDM_BASE 48'h0000_1000_0000
`define DMA_TCDM_SIZE 48'h0000_0002_0000

`endif

/* dma_fe_pkg.sv */
//--------------------------------------------------------------------
// DMA frontend package
// decoded views of the second accelerator argument
//--------------------------------------------------------------------
`include "dma_fe_params.svh"

package dma_fe_pkg;

    // DMSRC / DMDST: upper address bits above the first argument
    typedef struct packed {
        logic [`DMA_DATA_WIDTH-`DMA_ADDR_WIDTH+31:0] rsvd;
        logic [`DMA_ADDR_WIDTH-33:0]                 addr_hi;
    } dma_addr_word_t;

    // DMCPY / DMSTAT: config or status selector in the low bits
    // bit 1 of the config requests a two-dimensional transfer
    typedef struct packed {
        logic [`DMA_DATA_WIDTH-3:0] rsvd;
        logic [1:0]                 sel;
    } dma_cfg_word_t;

    typedef union packed {
        dma_addr_word_t addr;
        dma_cfg_word_t  cfg;
    } dma_arg_word_u;

endpackage

/* dma_fe_sva.sv */
//--------------------------------------------------------------------
// DMA frontend protocol checks
// handshake stability and done pulses against outstanding bursts
//--------------------------------------------------------------------
`timescale 1ns/100ps
`include "dma_fe_params.svh"

module dma_fe_sva (
    input logic                         clk_i,
    input logic                         arst_n_i,
    input logic                         acc_res_valid_o,
    input logic                         acc_res_ready_i,
    input logic [`DMA_DATA_WIDTH-1:0]   acc_res_data_o,
    input logic [`DMA_ACC_ID_WIDTH-1:0] acc_res_id_o,
    input logic                         burst_valid_o,
    input logic                         burst_ready_i,
    input logic [`DMA_ADDR_WIDTH-1:0]   burst_src_o,
    input logic [`DMA_ADDR_WIDTH-1:0]   burst_dst_o,
    input logic [`DMA_ADDR_WIDTH-1:0]   burst_len_o,
    input logic                         burst_src_obi_o,
    input logic                         burst_dst_obi_o,
    input logic                         burst_done_i
);

    // bursts handed to the backend and not yet answered
    logic [31:0] outstanding_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            outstanding_q <= '0;
        end else begin
            outstanding_q <= outstanding_q + 32'(burst_valid_o && burst_ready_i)
                             - 32'(burst_done_i);
        end
    end

    rsp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        acc_res_valid_o && !acc_res_ready_i |=>
            acc_res_valid_o && $stable(acc_res_data_o) && $stable(acc_res_id_o))
        else $error("response changed while the accelerator stalled it");

    burst_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        burst_valid_o && !burst_ready_i |=>
            burst_valid_o && $stable(burst_src_o) && $stable(burst_dst_o) &&
            $stable(burst_len_o) && $stable(burst_src_obi_o) && $stable(burst_dst_obi_o))
        else $error("burst changed while the backend stalled it");

    done_outstanding: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        burst_done_i |-> outstanding_q != '0)
        else $error("done pulse with no burst outstanding");

endmodule

bind dma_fe_top dma_fe_sva i_dma_fe_sva (.*);

/* dma_fe_top.sv */
//--------------------------------------------------------------------
// tightly coupled DMA frontend, single channel
// accelerator bus in, strided bursts out
//--------------------------------------------------------------------
`timescale 1ns/100ps
`include "dma_fe_params.svh"

module dma_fe_top (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    // accelerator request
    input  logic                         acc_req_valid_i,
    output logic                         acc_req_ready_o,
    input  logic [31:0]                  acc_req_op_i,
    input  logic [`DMA_DATA_WIDTH-1:0]   acc_req_arga_i,
    input  logic [`DMA_DATA_WIDTH-1:0]   acc_req_argb_i,
    input  logic [`DMA_ACC_ID_WIDTH-1:0] acc_req_id_i,
    // accelerator response
    output logic                         acc_res_valid_o,
    input  logic                         acc_res_ready_i,
    output logic [`DMA_DATA_WIDTH-1:0]   acc_res_data_o,
    output logic [`DMA_ACC_ID_WIDTH-1:0] acc_res_id_o,
    // bursts to the backend
    output logic                         burst_valid_o,
    input  logic                         burst_ready_i,
    output logic [`DMA_ADDR_WIDTH-1:0]   burst_src_o,
    output logic [`DMA_ADDR_WIDTH-1:0]   burst_dst_o,
    output logic [`DMA_ADDR_WIDTH-1:0]   burst_len_o,
    output logic                         burst_src_obi_o,
    output logic                         burst_dst_obi_o,
    input  logic                         burst_done_i,
    output logic                         busy_o
);

    dma_nd_req_if fe_req ();
    dma_nd_req_if nd_req ();

    logic                         fifo_full, fifo_empty;
    logic [`DMA_ID_WIDTH-1:0]     completed_id;
    logic                         rsp_valid, rsp_ready;
    logic [`DMA_DATA_WIDTH-1:0]   rsp_data;
    logic [`DMA_ACC_ID_WIDTH-1:0] rsp_id;

    dma_inst_decode i_dma_inst_decode (
        .clk_i,
        .arst_n_i,
        .acc_req_valid_i,
        .acc_req_op_i,
        .acc_req_arga_i,
        .acc_req_argb_i,
        .acc_req_id_i,
        .acc_req_ready_o,
        .fifo_full_i    ( fifo_full    ),
        .completed_id_i ( completed_id ),
        .busy_i         ( busy_o       ),
        .rsp_ready_i    ( rsp_ready    ),
        .rsp_valid_o    ( rsp_valid    ),
        .rsp_data_o     ( rsp_data     ),
        .rsp_id_o       ( rsp_id       ),
        .req            ( fe_req       )
    );

    dma_req_fifo i_dma_req_fifo (
        .clk_i,
        .arst_n_i,
        .full_o  ( fifo_full  ),
        .empty_o ( fifo_empty ),
        .in      ( fe_req     ),
        .out     ( nd_req     )
    );

    dma_nd_midend i_dma_nd_midend (
        .clk_i,
        .arst_n_i,
        .fifo_empty_i   ( fifo_empty   ),
        .burst_ready_i,
        .burst_done_i,
        .burst_valid_o,
        .burst_src_o,
        .burst_dst_o,
        .burst_len_o,
        .burst_src_obi_o,
        .burst_dst_obi_o,
        .completed_id_o ( completed_id ),
        .busy_o,
        .req            ( nd_req       )
    );

    // decouples the response path from the accelerator bus
    dma_rsp_spill i_dma_rsp_spill (
        .clk_i,
        .arst_n_i,
        .valid_i ( rsp_valid       ),
        .ready_o ( rsp_ready       ),
        .data_i  ( rsp_data        ),
        .id_i    ( rsp_id          ),
        .valid_o ( acc_res_valid_o ),
        .ready_i ( acc_res_ready_i ),
        .data_o  ( acc_res_data_o  ),
        .id_o    ( acc_res_id_o    )
    );

endmodule

/* dma_inst_decode.sv */
//--------------------------------------------------------------------
// DMA instruction decoder
// holds the transfer config registers and the next id, issues copies
// into the request FIFO and answers status queries
//--------------------------------------------------------------------
`timescale 1ns/100ps
`include "dma_fe_params.svh"

module dma_inst_decode (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         acc_req_valid_i,
    input  logic [31:0]                  acc_req_op_i,
    input  logic [`DMA_DATA_WIDTH-1:0]   acc_req_arga_i,
    input  logic [`DMA_DATA_WIDTH-1:0]   acc_req_argb_i,
    input  logic [`DMA_ACC_ID_WIDTH-1:0] acc_req_id_i,
    output logic                         acc_req_ready_o,
    input  logic                         fifo_full_i,
    input  logic [`DMA_ID_WIDTH-1:0]     completed_id_i,
    input  logic                         busy_i,
    input  logic                         rsp_ready_i,
    output logic                         rsp_valid_o,
    output logic [`DMA_DATA_WIDTH-1:0]   rsp_data_o,
    output logic [`DMA_ACC_ID_WIDTH-1:0] rsp_id_o,
    dma_nd_req_if.producer               req
);

    import dma_fe_pkg::*;

    dma_arg_word_u              arg_w;
    logic [6:0]                 func;
    logic [1:0]                 sel;
    logic                       imm_form;
    logic [`DMA_DATA_WIDTH-1:0] status_data;

    // config registers
    logic [`DMA_ADDR_WIDTH-1:0] src_q, dst_q;
    logic [`DMA_REP_WIDTH-1:0]  src_stride_q, dst_stride_q, reps_q;
    logic [`DMA_ID_WIDTH-1:0]   next_id_q;

    assign arg_w    = acc_req_argb_i;
    assign func     = acc_req_op_i[6:0];
    assign imm_form = (func == `DMA_OP_DMCPYI) || (func == `DMA_OP_DMSTATI);
    assign sel      = imm_form ? acc_req_op_i[`DMA_IMM_LSB +: 2] : arg_w.cfg.sel;

    // request payload, reps collapses to one unless 2D is selected
    assign req.src        = src_q;
    assign req.dst        = dst_q;
    assign req.len        = acc_req_arga_i[`DMA_ADDR_WIDTH-1:0];
    assign req.src_stride = src_stride_q;
    assign req.dst_stride = dst_stride_q;
    assign req.reps       = sel[1] ? reps_q : `DMA_REP_WIDTH'(1);

    assign rsp_id_o = acc_req_id_i;

    always_comb begin
        case (sel)
            2'd0:    status_data = `DMA_DATA_WIDTH'(completed_id_i);
            2'd1:    status_data = `DMA_DATA_WIDTH'(next_id_q);
            2'd2:    status_data = `DMA_DATA_WIDTH'(busy_i);
            default: status_data = `DMA_DATA_WIDTH'(fifo_full_i);
        endcase
    end

    //--------------------------------------------------------------------
    // decode and handshake
    //--------------------------------------------------------------------
    always_comb begin
        acc_req_ready_o = 1'b0;
        rsp_valid_o     = 1'b0;
        rsp_data_o      = '0;
        req.valid       = 1'b0;
        if (acc_req_valid_i) begin
            case (func)
                `DMA_OP_DMSRC, `DMA_OP_DMDST, `DMA_OP_DMSTR, `DMA_OP_DMREP: begin
                    acc_req_ready_o = 1'b1;
                end
                `DMA_OP_DMCPY, `DMA_OP_DMCPYI: begin
                    // response slot first, then the FIFO
                    req.valid = rsp_ready_i;
                    if (rsp_ready_i && req.ready) begin
                        acc_req_ready_o = 1'b1;
                        rsp_valid_o     = 1'b1;
                        rsp_data_o      = `DMA_DATA_WIDTH'(next_id_q);
                    end
                end
                `DMA_OP_DMSTAT, `DMA_OP_DMSTATI: begin
                    acc_req_ready_o = rsp_ready_i;
                    rsp_valid_o     = rsp_ready_i;
                    rsp_data_o      = status_data;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (acc_req_valid_i) begin
            case (func)
                `DMA_OP_DMSRC: src_q <= {arg_w.addr.addr_hi, acc_req_arga_i[31:0]};
                `DMA_OP_DMDST: dst_q <= {arg_w.addr.addr_hi, acc_req_arga_i[31:0]};
                `DMA_OP_DMSTR: begin
                    src_stride_q <= acc_req_arga_i[`DMA_REP_WIDTH-1:0];
                    dst_stride_q <= acc_req_argb_i[`DMA_REP_WIDTH-1:0];
                end
                `DMA_OP_DMREP: reps_q <= acc_req_arga_i[`DMA_REP_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // ids start at one
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            next_id_q <= `DMA_ID_WIDTH'(1);
        end else if (req.valid && req.ready) begin
            next_id_q <= next_id_q + `DMA_ID_WIDTH'(1);
        end
    end

endmodule

/* dma_nd_midend.sv */
//--------------------------------------------------------------------
// 2D midend
// splits a request into strided bursts, tags each endpoint as TCDM
// or system, and retires the transfer once every burst is done
//--------------------------------------------------------------------
`timescale 1ns/100ps
`include "dma_fe_params.svh"

module dma_nd_midend (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       fifo_empty_i,
    input  logic                       burst_ready_i,
    input  logic                       burst_done_i,
    output logic                       burst_valid_o,
    output logic [`DMA_ADDR_WIDTH-1:0] burst_src_o,
    output logic [`DMA_ADDR_WIDTH-1:0] burst_dst_o,
    output logic [`DMA_ADDR_WIDTH-1:0] burst_len_o,
    output logic                       burst_src_obi_o,
    output logic                       burst_dst_obi_o,
    output logic [`DMA_ID_WIDTH-1:0]   completed_id_o,
    output logic                       busy_o,
    dma_nd_req_if.consumer             req
);

    // current transfer, addresses advance by one stride per burst
    logic [`DMA_ADDR_WIDTH-1:0] cur_src_q, cur_dst_q, len_q;
    logic [`DMA_REP_WIDTH-1:0]  src_stride_q, dst_stride_q, reps_q;
    logic [`DMA_REP_WIDTH-1:0]  issued_q, done_q;
    logic [`DMA_ID_WIDTH-1:0]   completed_q;
    logic                       active_q;
    logic                       take, issue, last_done;

    function automatic logic in_tcdm(input logic [`DMA_ADDR_WIDTH-1:0] addr);
        return (addr >= `DMA_TCDM_BASE) && (addr < `DMA_TCDM_BASE + `DMA_TCDM_SIZE);
    endfunction

    assign req.ready = !active_q;
    assign take      = req.valid && req.ready;
    assign issue     = burst_valid_o && burst_ready_i;
    assign last_done = burst_done_i && (done_q + 1'b1 == reps_q);

    assign burst_valid_o   = active_q && (issued_q != reps_q);
    assign burst_src_o     = cur_src_q;
    assign burst_dst_o     = cur_dst_q;
    assign burst_len_o     = len_q;
    assign burst_src_obi_o = in_tcdm(cur_src_q);
    assign burst_dst_obi_o = in_tcdm(cur_dst_q);
    assign completed_id_o  = completed_q;
    assign busy_o          = active_q || !fifo_empty_i;

    always_ff @(posedge clk_i) begin
        if (take) begin
            cur_src_q    <= req.src;
            cur_dst_q    <= req.dst;
            len_q        <= req.len;
            src_stride_q <= req.src_stride;
            dst_stride_q <= req.dst_stride;
            reps_q       <= req.reps;
        end else if (issue) begin
            cur_src_q <= cur_src_q + `DMA_ADDR_WIDTH'(src_stride_q);
            cur_dst_q <= cur_dst_q + `DMA_ADDR_WIDTH'(dst_stride_q);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q    <= 1'b0;
            issued_q    <= '0;
            done_q      <= '0;
            completed_q <= '0;
        end else if (take) begin
            active_q <= 1'b1;
            issued_q <= '0;
            done_q   <= '0;
        end else begin
            if (issue) begin
                issued_q <= issued_q + 1'b1;
            end
            if (burst_done_i) begin
                done_q <= done_q + 1'b1;
            end
            // retire on the last done pulse
            if (last_done) begin
                active_q    <= 1'b0;
                completed_q <= completed_q + 1'b1;
            end
        end
    end

endmodule

/* dma_nd_req_if.sv */
//--------------------------------------------------------------------
// two-dimensional transfer request channel
//--------------------------------------------------------------------
`timescale 1ns/100ps
`include "dma_fe_params.svh"

interface dma_nd_req_if;

    logic                        valid;
    logic                        ready;
    logic [`DMA_ADDR_WIDTH-1:0]  src;
    logic [`DMA_ADDR_WIDTH-1:0]  dst;
    logic [`DMA_ADDR_WIDTH-1:0]  len;
    logic [`DMA_REP_WIDTH-1:0]   src_stride;
    logic [`DMA_REP_WIDTH-1:0]   dst_stride;
    // already one for a 1D copy
    logic [`DMA_REP_WIDTH-1:0]   reps;

    modport producer (
        output valid, src, dst, len, src_stride, dst_stride, reps,
        input  ready
    );

    modport consumer (
        input  valid, src, dst, len, src_stride, dst_stride, reps,
        output ready
    );

endinterface

/* dma_req_fifo.sv */
//--------------------------------------------------------------------
// request FIFO between the decoder and the 2D midend
//--------------------------------------------------------------------
`timescale 1ns/100ps
`include "dma_fe_params.svh"

module dma_req_fifo (
    input  logic           clk_i,
    input  logic           arst_n_i,
    output logic           full_o,
    output logic           empty_o,
    dma_nd_req_if.consumer in,
    dma_nd_req_if.producer out
);

    localparam int unsigned Depth  = `DMA_FIFO_DEPTH;
    localparam int unsigned PtrW   = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntW   = $clog2(Depth + 1);
    localparam int unsigned EntryW = 3 * `DMA_ADDR_WIDTH + 3 * `DMA_REP_WIDTH;

    logic [EntryW-1:0] mem [Depth];
    logic [PtrW-1:0]   wr_ptr_q, rd_ptr_q;
    logic [CntW-1:0]   count_q;
    logic              push, pop;

    assign full_o   = (count_q == CntW'(Depth));
    assign empty_o  = (count_q == '0);
    assign in.ready = !full_o;
    assign push     = in.valid && in.ready;

    assign out.valid = !empty_o;
    assign pop       = out.valid && out.ready;
    assign {out.src, out.dst, out.len, out.src_stride, out.dst_stride, out.reps} =
        mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= {in.src, in.dst, in.len, in.src_stride, in.dst_stride, in.reps};
        end
    end

    // pointers wrap at the last slot
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CntW'(push) - CntW'(pop);
        end
    end

endmodule

/* dma_rsp_spill.sv */
//--------------------------------------------------------------------
// two-slot spill register on the accelerator response path
//--------------------------------------------------------------------
`timescale 1ns/100ps
`include "dma_fe_params.svh"

module dma_rsp_spill (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         valid_i,
    output logic                         ready_o,
    input  logic [`DMA_DATA_WIDTH-1:0]   data_i,
    input  logic [`DMA_ACC_ID_WIDTH-1:0] id_i,
    output logic                         valid_o,
    input  logic                         ready_i,
    output logic [`DMA_DATA_WIDTH-1:0]   data_o,
    output logic [`DMA_ACC_ID_WIDTH-1:0] id_o
);

    localparam int unsigned W = `DMA_DATA_WIDTH + `DMA_ACC_ID_WIDTH;

    // slot a takes new entries, slot b holds the older one when stalled
    logic [W-1:0] a_q, b_q;
    logic         a_full_q, b_full_q;
    logic         a_fill, a_drain, b_fill, b_drain;

    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    assign ready_o          = !a_full_q || !b_full_q;
    assign valid_o          = a_full_q || b_full_q;
    assign {id_o, data_o}   = b_full_q ? b_q : a_q;

    always_ff @(posedge clk_i) begin
        if (a_fill) begin
            a_q <= {id_i, data_i};
        end
        if (b_fill) begin
            b_q <= a_q;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            a_full_q <= 1'b0;
            b_full_q <= 1'b0;
        end else begin
            if (a_fill || a_drain) begin
                a_full_q <= a_fill;
            end
            if (b_fill || b_drain) begin
                b_full_q <= b_fill;
            end
        end
    end

endmodule

/* filelist.f */
+incdir+.
dma_fe_pkg.sv
dma_nd_req_if.sv
dma_inst_decode.sv
dma_req_fifo.sv
dma_nd_midend.sv
dma_rsp_spill.sv
dma_fe_top.sv
dma_fe_sva.sv
tb_dma_fe.sv

/* run.sh */
#!/bin/sh
# build the DMA frontend testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dma_fe -f filelist.f || exit 1
out=$(./obj_dir/Vtb_dma_fe)
echo "$out"
echo "$out" | grep -qx "Done: no errors" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tb_dma_fe.sv */
//--------------------------------------------------------------------
// DMA frontend testbench
// replays the case file on the accelerator bus, models the burst
// backend and checks every response and burst
//--------------------------------------------------------------------
`timescale 1ns/100ps
`include "dma_fe_params.svh"

module tb_dma_fe;

    localparam int BurstW = 3 * `DMA_ADDR_WIDTH + 2;

    logic                         clk_i, arst_n_i;
    logic                         acc_req_valid_i, acc_req_ready_o;
    logic [31:0]                  acc_req_op_i;
    logic [`DMA_DATA_WIDTH-1:0]   acc_req_arga_i, acc_req_argb_i;
    logic [`DMA_ACC_ID_WIDTH-1:0] acc_req_id_i;
    logic                         acc_res_valid_o;
    logic [`DMA_DATA_WIDTH-1:0]   acc_res_data_o;
    logic [`DMA_ACC_ID_WIDTH-1:0] acc_res_id_o;
    logic                         burst_valid_o, busy_o;
    logic [`DMA_ADDR_WIDTH-1:0]   burst_src_o, burst_dst_o, burst_len_o;
    logic                         burst_src_obi_o, burst_dst_obi_o;
    logic                         acc_res_ready_i = 1'b0;
    logic                         burst_ready_i = 1'b0;
    logic                         burst_done_i = 1'b0;

    // expected traffic and backend state
    logic [`DMA_DATA_WIDTH-1:0]   rsp_exp_data [$];
    logic [`DMA_ACC_ID_WIDTH-1:0] rsp_exp_id [$];
    logic [BurstW-1:0]            burst_exp [$];
    int                           done_due [$];
    string                        lines [$];
    logic [31:0]                  lfsr_q = 32'h4e4d;
    logic [`DMA_ACC_ID_WIDTH-1:0] tag_q;
    logic                         burst_taken;
    int                           cycle = 0;
    int                           limit = 0;
    int                           due, errors, ntests;

    dma_fe_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[6:0], fb};
        end
        return v;
    endfunction

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("timeout: the run did not end within %0d cycles", limit);
            $display("Done: errors found");
            $finish;
        end
    end

    //----------------------------------------------------------------------
    // backend model returning done pulses in order after a random delay
    //----------------------------------------------------------------------
    always @(posedge clk_i) begin
        #1;
        if (burst_taken) begin
            due = cycle + 1 + int'(rand_bits(3));
            if (done_due.size() != 0 && due <= done_due[done_due.size()-1]) begin
                due = done_due[done_due.size()-1] + 1;
            end
            done_due.push_back(due);
        end
        burst_done_i = (done_due.size() != 0 && done_due[0] <= cycle);
        if (burst_done_i) begin
            void'(done_due.pop_front());
        end
        burst_ready_i   = (rand_bits(2) != 8'd0);
        acc_res_ready_i = (rand_bits(2) != 8'd0);
    end

    // checks at the falling edge what the DUT hands over in this cycle
    task automatic tick();
        logic [BurstW-1:0] got;
        @(negedge clk_i);
        got = {burst_src_o, burst_dst_o, burst_len_o, burst_src_obi_o, burst_dst_obi_o};
        burst_taken = burst_valid_o && burst_ready_i;
        // a transfer with bursts still awaiting done stays busy
        assert (done_due.size() == 0 || busy_o) else begin
            errors++;
            $display("mismatch at %0t: busy_o low with %0d bursts awaiting done",
                     $time, done_due.size());
        end
        if (acc_res_valid_o && acc_res_ready_i) begin
            if (rsp_exp_data.size() == 0) begin
                errors++;
                $display("response with id %0d arrived with no request waiting", acc_res_id_o);
            end else begin
                assert (acc_res_data_o == rsp_exp_data[0] && acc_res_id_o == rsp_exp_id[0])
                else begin
                    errors++;
                    $display("mismatch at %0t: response %h id %0d, expected %h id %0d",
                             $time, acc_res_data_o, acc_res_id_o,
                             rsp_exp_data[0], rsp_exp_id[0]);
                end
                void'(rsp_exp_data.pop_front());
                void'(rsp_exp_id.pop_front());
            end
        end
        if (burst_taken) begin
            if (burst_exp.size() == 0) begin
                errors++;
                $display("burst to %h issued that no copy asked for", burst_dst_o);
            end else begin
                assert (got == burst_exp[0]) else begin
                    errors++;
                    $display("mismatch at %0t: burst %h, expected %h", $time, got, burst_exp[0]);
                end
                void'(burst_exp.pop_front());
            end
        end
    endtask

    task automatic send_req(input logic [31:0] op, input logic [63:0] arga,
                            input logic [63:0] argb, input int rsp, input logic [63:0] exp_data);
        acc_req_valid_i = 1'b1;
        acc_req_op_i    = op;
        acc_req_arga_i  = arga;
        acc_req_argb_i  = argb;
        acc_req_id_i    = tag_q;
        tick();
        while (!acc_req_ready_o) begin
            tick();
        end
        if (rsp != 0) begin
            rsp_exp_data.push_back(exp_data);
            rsp_exp_id.push_back(tag_q);
        end
        tag_q = tag_q + 1'b1;
        @(posedge clk_i);
        #1;
        acc_req_valid_i = 1'b0;
    endtask

    // drain responses and done pulses until the frontend is idle
    task automatic end_test(input logic [127:0] name, input int err_start);
        tick();
        while (busy_o || rsp_exp_data.size() != 0 || done_due.size() != 0) begin
            tick();
        end
        assert (burst_exp.size() == 0) else begin
            errors++;
            $display("test %0s: %0d expected bursts were never issued", name, burst_exp.size());
            burst_exp.delete();
        end
        ntests++;
        $display("test %0s finished with %0d errors", name, errors - err_start);
        @(posedge clk_i);
        #1;
    endtask

    initial begin
        int                         fd, idx, rsp, nb, err_start, sobi, dobi;
        string                      line;
        logic [127:0]               name, cur_test, kw;
        logic [31:0]                op;
        logic [63:0]                arga, argb, exp_data;
        logic [`DMA_ADDR_WIDTH-1:0] bsrc, bdst, blen;
        arst_n_i        = 1'b0;
        acc_req_valid_i = 1'b0;
        acc_req_op_i    = '0;
        acc_req_arga_i  = '0;
        acc_req_argb_i  = '0;
        acc_req_id_i    = '0;
        tag_q           = '0;
        burst_taken     = 1'b0;
        errors          = 0;
        ntests          = 0;
        err_start       = 0;
        cur_test        = '0;
        fd = $fopen("dma_fe_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the case file dma_fe_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        limit = 200 * (lines.size() + 1);
        repeat (10) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        idx = 0;
        while (idx < lines.size()) begin
            void'($sscanf(lines[idx], "%s %h %h %h %d %h %d",
                          name, op, arga, argb, rsp, exp_data, nb));
            idx++;
            if (name != cur_test) begin
                if (cur_test != '0) begin
                    end_test(cur_test, err_start);
                end
                cur_test  = name;
                err_start = errors;
            end
            // burst lines of a copy follow it directly
            for (int k = 0; k < nb && idx < lines.size(); k++) begin
                void'($sscanf(lines[idx], "%s %h %h %h %d %d", kw, bsrc, bdst, blen, sobi, dobi));
                burst_exp.push_back({bsrc, bdst, blen, sobi[0], dobi[0]});
                idx++;
            end
            send_req(op, arga, argb, rsp, exp_data);
        end
        if (cur_test != '0) begin
            end_test(cur_test, err_start);
        end
        $display("%0d tests run, %0d errors", ntests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
